// File: all.f
hw/dma_frontend_pkg.sv
hw/dma_frontend_regs.sv
hw/dma_frontend_arbiter.sv
hw/dma_transfer_id_tracker.sv
hw/dma_frontend_top.sv
tb/tb_clock_gen.sv
tb/dma_frontend_monitor.sv
tb/dma_frontend_checker.sv
tb/tb_dma_frontend.sv

// File: hw/dma_frontend_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dma_frontend_arbiter (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    input  wire logic [dma_frontend_pkg::NUM_PE-1:0]    req_i,
    input  wire dma_frontend_pkg::transf_descr_t [dma_frontend_pkg::NUM_PE-1:0] descr_i,
    input  wire logic                                   ready_i,
    output      logic [dma_frontend_pkg::NUM_PE-1:0]    grant_o,
    output      dma_frontend_pkg::transf_descr_t        descr_o,
    output      logic                                   valid_o
);

    logic [dma_frontend_pkg::PE_IDX_W-1:0] ptr_d, ptr_q;
    logic [dma_frontend_pkg::PE_IDX_W-1:0] win_idx;
    logic                                  found;

    // first requester at or after the pointer
    always_comb begin : proc_pick
        int unsigned cand;
        found   = 1'b0;
        win_idx = ptr_q;
        for (int unsigned off = 0; off < dma_frontend_pkg::NUM_PE; off++) begin
            cand = int'(ptr_q) + off;
            if (cand >= dma_frontend_pkg::NUM_PE) begin
                cand = cand - dma_frontend_pkg::NUM_PE;
            end
            if (!found && req_i[cand]) begin
                found   = 1'b1;
                win_idx = cand[dma_frontend_pkg::PE_IDX_W-1:0];
            end
        end
    end

    assign valid_o = |req_i;
    assign descr_o = descr_i[win_idx];

    always_comb begin : proc_grant
        grant_o = '0;
        if (found && ready_i) begin
            grant_o[win_idx] = 1'b1;
        end
    end

    // pointer moves past the winner only when the backend accepts
    always_comb begin : proc_ptr_next
        int unsigned nxt;
        nxt   = int'(win_idx) + 1;
        ptr_d = ptr_q;
        if (nxt >= dma_frontend_pkg::NUM_PE) begin
            nxt = 0;
        end
        if (valid_o && ready_i) begin
            ptr_d = nxt[dma_frontend_pkg::PE_IDX_W-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptr
        if (!rst_ni) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/dma_frontend_pkg.sv
`default_nettype none

package dma_frontend_pkg;

    // number of PE ports on the frontend
    localparam int unsigned NUM_PE   = 4;
    localparam int unsigned PE_IDX_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

    localparam int unsigned ID_WIDTH = 32;
    localparam logic [ID_WIDTH-1:0] ID_ONE = 1;

    // register offsets, decoded on addr[5:0]
    localparam logic [5:0] REG_SRC     = 6'h00;
    localparam logic [5:0] REG_DST     = 6'h08;
    localparam logic [5:0] REG_NUM     = 6'h10;
    localparam logic [5:0] REG_NEXT_ID = 6'h18;
    localparam logic [5:0] REG_DONE_ID = 6'h20;
    localparam logic [5:0] REG_STATUS  = 6'h28;

    // serialize, deburst, decouple
    localparam logic [2:0] CONF_RESET = 3'b101;

    localparam int unsigned STATUS_BUSY_BIT = 16;

    // TCDM request from one PE
    typedef struct packed {
        logic        req;
        logic        rd;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } tcdm_req_t;

    // TCDM response to one PE
    typedef struct packed {
        logic        gnt;
        logic        valid;
        logic [31:0] rdata;
    } tcdm_rsp_t;

    // descriptor handed to the backend
    typedef struct packed {
        logic [31:0] num_bytes;
        logic [31:0] dst_addr;
        logic [31:0] src_addr;
        logic        decouple;
        logic        deburst;
        logic        serialize;
    } transf_descr_t;

    // the three stored words seen as descriptor fields
    typedef struct packed {
        logic [31:0] num_bytes;
        logic [31:0] dst_addr;
        logic [31:0] src_addr;
    } descr_words_t;

    // word 0 is src, word 1 dst, word 2 num_bytes
    typedef union packed {
        logic [2:0][31:0]      words;
        logic [2:0][3:0][7:0]  bytes;
        descr_words_t          transfer;
    } dma_data_store_t;

endpackage

`default_nettype wire

// File: hw/dma_frontend_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_frontend_regs (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    // TCDM port of one PE
    input  wire dma_frontend_pkg::tcdm_req_t            ctrl_req_i,
    output      dma_frontend_pkg::tcdm_rsp_t            ctrl_rsp_o,
    // from the id tracker
    input  wire logic [dma_frontend_pkg::ID_WIDTH-1:0]  next_id_i,
    input  wire logic [dma_frontend_pkg::ID_WIDTH-1:0]  done_id_i,
    input  wire logic                                   busy_i,
    // launch handshake with the arbiter
    input  wire logic                                   launch_ready_i,
    output      logic                                   launch_req_o,
    output      dma_frontend_pkg::transf_descr_t        descr_o
);

    logic [5:0]  reg_off;
    logic [1:0]  word_idx;
    logic [31:0] status_word;

    dma_frontend_pkg::dma_data_store_t store_d, store_q;
    logic [2:0]  conf_d, conf_q;

    logic        gnt;
    logic [31:0] rdata_d, rdata_q;
    logic        valid_q;

    assign reg_off  = ctrl_req_i.addr[5:0];
    // 0x00, 0x08 and 0x10 map to words 0..2
    assign word_idx = reg_off[4:3];

    always_comb begin : proc_status
        status_word = '0;
        status_word[dma_frontend_pkg::STATUS_BUSY_BIT] = busy_i;
        status_word[2:0] = conf_q;
    end

    always_comb begin : proc_decode
        store_d      = store_q;
        conf_d       = conf_q;
        rdata_d      = '0;
        gnt          = 1'b0;
        launch_req_o = 1'b0;

        if (ctrl_req_i.req) begin
            gnt = 1'b1;
            case (reg_off)
                dma_frontend_pkg::REG_SRC,
                dma_frontend_pkg::REG_DST,
                dma_frontend_pkg::REG_NUM: begin
                    if (ctrl_req_i.rd) begin
                        rdata_d = store_q.words[word_idx];
                    end else begin
                        // merge only the enabled bytes
                        for (int i = 0; i < 4; i++) begin
                            if (ctrl_req_i.be[i]) begin
                                store_d.bytes[word_idx][i] = ctrl_req_i.wdata[8*i +: 8];
                            end
                        end
                    end
                end
                dma_frontend_pkg::REG_NEXT_ID: begin
                    // a read here is the launch, held until the backend takes it
                    if (ctrl_req_i.rd) begin
                        launch_req_o = 1'b1;
                        gnt          = launch_ready_i;
                        rdata_d      = next_id_i;
                    end
                end
                dma_frontend_pkg::REG_DONE_ID: begin
                    if (ctrl_req_i.rd) begin
                        rdata_d = done_id_i;
                    end
                end
                dma_frontend_pkg::REG_STATUS: begin
                    if (ctrl_req_i.rd) begin
                        rdata_d = status_word;
                    end else begin
                        conf_d = ctrl_req_i.wdata[2:0];
                    end
                end
                default: begin
                    // unmapped reads as zero
                    rdata_d = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
        if (!rst_ni) begin
            store_q <= '0;
            conf_q  <= dma_frontend_pkg::CONF_RESET;
            valid_q <= 1'b0;
        end else begin
            store_q <= store_d;
            conf_q  <= conf_d;
            valid_q <= gnt;
        end
    end

    always_ff @(posedge clk_i) begin : proc_rdata
        rdata_q <= rdata_d;
    end

    assign ctrl_rsp_o.gnt   = gnt;
    assign ctrl_rsp_o.valid = valid_q;
    assign ctrl_rsp_o.rdata = rdata_q;

    assign descr_o.num_bytes = store_q.transfer.num_bytes;
    assign descr_o.dst_addr  = store_q.transfer.dst_addr;
    assign descr_o.src_addr  = store_q.transfer.src_addr;
    assign descr_o.decouple  = conf_q[0];
    assign descr_o.deburst   = conf_q[1];
    assign descr_o.serialize = conf_q[2];

endmodule

`default_nettype wire

// File: hw/dma_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_frontend_top (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    // PE ports
    input  wire dma_frontend_pkg::tcdm_req_t [dma_frontend_pkg::NUM_PE-1:0] pe_req_i,
    output      dma_frontend_pkg::tcdm_rsp_t [dma_frontend_pkg::NUM_PE-1:0] pe_rsp_o,
    // backend descriptor port
    output      dma_frontend_pkg::transf_descr_t        desc_o,
    output      logic                                   desc_valid_o,
    input  wire logic                                   desc_ready_i,
    // backend completion
    input  wire logic                                   done_i
);

    logic [dma_frontend_pkg::NUM_PE-1:0]   launch_req;
    logic [dma_frontend_pkg::NUM_PE-1:0]   launch_ready;
    dma_frontend_pkg::transf_descr_t [dma_frontend_pkg::NUM_PE-1:0] pe_descr;

    logic [dma_frontend_pkg::ID_WIDTH-1:0] next_id;
    logic [dma_frontend_pkg::ID_WIDTH-1:0] done_id;
    logic                                  busy;
    logic                                  accept;

    // descriptor taken by the backend
    assign accept = desc_valid_o & desc_ready_i;

    for (genvar p = 0; p < dma_frontend_pkg::NUM_PE; p++) begin : gen_pe_regs
        dma_frontend_regs i_regs (
            .clk_i          (clk_i),
            .rst_ni         (rst_ni),
            .ctrl_req_i     (pe_req_i[p]),
            .ctrl_rsp_o     (pe_rsp_o[p]),
            .next_id_i      (next_id),
            .done_id_i      (done_id),
            .busy_i         (busy),
            .launch_ready_i (launch_ready[p]),
            .launch_req_o   (launch_req[p]),
            .descr_o        (pe_descr[p])
        );
    end

    dma_frontend_arbiter i_arbiter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (launch_req),
        .descr_i (pe_descr),
        .ready_i (desc_ready_i),
        .grant_o (launch_ready),
        .descr_o (desc_o),
        .valid_o (desc_valid_o)
    );

    dma_transfer_id_tracker i_id_tracker (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .launch_i  (accept),
        .done_i    (done_i),
        .next_id_o (next_id),
        .done_id_o (done_id),
        .busy_o    (busy)
    );

endmodule

`default_nettype wire

// File: hw/dma_transfer_id_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module dma_transfer_id_tracker (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    // one pulse per accepted descriptor
    input  wire logic                                   launch_i,
    // one pulse per finished transfer
    input  wire logic                                   done_i,
    output      logic [dma_frontend_pkg::ID_WIDTH-1:0]  next_id_o,
    output      logic [dma_frontend_pkg::ID_WIDTH-1:0]  done_id_o,
    output      logic                                   busy_o
);

    logic [dma_frontend_pkg::ID_WIDTH-1:0] next_id_q;
    logic [dma_frontend_pkg::ID_WIDTH-1:0] done_id_q;
    logic [dma_frontend_pkg::ID_WIDTH-1:0] last_id;

    // ids start at 1, both counters wrap
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_next_id
        if (!rst_ni) begin
            next_id_q <= dma_frontend_pkg::ID_ONE;
        end else if (launch_i) begin
            next_id_q <= next_id_q + dma_frontend_pkg::ID_ONE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_done_id
        if (!rst_ni) begin
            done_id_q <= '0;
        end else if (done_i) begin
            done_id_q <= done_id_q + dma_frontend_pkg::ID_ONE;
        end
    end

    // last id handed out
    assign last_id = next_id_q - dma_frontend_pkg::ID_ONE;

    // outstanding until the last launched id has completed
    assign busy_o = (last_id != done_id_q);

    assign next_id_o = next_id_q;
    assign done_id_o = done_id_q;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the DMA frontend regression with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_frontend -f all.f -o sim_dma_frontend &&
./obj_dir/sim_dma_frontend | tee /dev/stderr | grep -q "Regression passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: tb/dma_frontend_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dma_frontend_checker (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,
    input  wire dma_frontend_pkg::tcdm_req_t [dma_frontend_pkg::NUM_PE-1:0] pe_req_i,
    input  wire dma_frontend_pkg::tcdm_rsp_t [dma_frontend_pkg::NUM_PE-1:0] pe_rsp_o,
    input  wire dma_frontend_pkg::transf_descr_t        desc_o,
    input  wire logic                                   desc_valid_o,
    input  wire logic                                   desc_ready_i
);

    logic any_launch;

    // some PE is reading the next-id register
    always_comb begin
        any_launch = 1'b0;
        for (int p = 0; p < dma_frontend_pkg::NUM_PE; p++) begin
            if (pe_req_i[p].req && pe_req_i[p].rd &&
                pe_req_i[p].addr[5:0] == dma_frontend_pkg::REG_NEXT_ID) begin
                any_launch = 1'b1;
            end
        end
    end

    for (genvar p = 0; p < dma_frontend_pkg::NUM_PE; p++) begin : gen_pe
        valid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
            pe_rsp_o[p].gnt |=> pe_rsp_o[p].valid)
            else $error("PE %0d valid missing after grant", p);
        gnt_before_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
            pe_rsp_o[p].valid |-> $past(pe_rsp_o[p].gnt))
            else $error("PE %0d valid without earlier grant", p);
        gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
            pe_rsp_o[p].gnt |-> pe_req_i[p].req)
            else $error("PE %0d grant without request", p);
    end

    desc_valid_src: assert property (@(posedge clk_i) disable iff (!rst_ni)
        desc_valid_o |-> any_launch)
        else $error("descriptor valid without a pending launch");

    desc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        desc_valid_o && !desc_ready_i |=> $stable(desc_o))
        else $error("descriptor changed while stalled");

endmodule

bind dma_frontend_top dma_frontend_checker i_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pe_req_i     (pe_req_i),
    .pe_rsp_o     (pe_rsp_o),
    .desc_o       (desc_o),
    .desc_valid_o (desc_valid_o),
    .desc_ready_i (desc_ready_i)
);

`default_nettype wire

// File: tb/dma_frontend_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module dma_frontend_monitor (
    input  wire logic                                   clk_i,
    input  wire dma_frontend_pkg::tcdm_req_t [dma_frontend_pkg::NUM_PE-1:0] pe_req_i,
    input  wire dma_frontend_pkg::tcdm_rsp_t [dma_frontend_pkg::NUM_PE-1:0] pe_rsp_i,
    input  wire dma_frontend_pkg::transf_descr_t        desc_i,
    input  wire logic                                   desc_valid_i,
    input  wire logic                                   desc_ready_i,
    // expectations from the testbench model
    input  wire logic [dma_frontend_pkg::NUM_PE-1:0]    chk_en_i,
    input  wire logic [dma_frontend_pkg::NUM_PE-1:0]    desc_chk_i,
    input  wire logic [dma_frontend_pkg::NUM_PE-1:0][31:0] exp_rdata_i,
    input  wire dma_frontend_pkg::transf_descr_t [dma_frontend_pkg::NUM_PE-1:0] exp_desc_i,
    input  wire logic [127:0]                           name_i,
    input  wire logic                                   timeout_i,
    input  wire logic                                   finish_i,
    output      logic [dma_frontend_pkg::NUM_PE-1:0]    seen_o,
    output      int                                     err_count_o
);

    int test_count;
    logic summary_done;
    logic [dma_frontend_pkg::NUM_PE-1:0] desc_bad;
    dma_frontend_pkg::transf_descr_t [dma_frontend_pkg::NUM_PE-1:0] desc_got;

    initial begin
        seen_o       = '0;
        desc_bad     = '0;
        desc_got     = '0;
        err_count_o  = 0;
        test_count   = 0;
        summary_done = 1'b0;
    end

    // sample away from the rising edge where the driver changes inputs
    always @(negedge clk_i) begin
        for (int p = 0; p < dma_frontend_pkg::NUM_PE; p++) begin
            if (!chk_en_i[p]) begin
                seen_o[p]   <= 1'b0;
                desc_bad[p] <= 1'b0;
            end else begin
                // launch accepted this cycle
                if (pe_rsp_i[p].gnt && pe_req_i[p].rd &&
                    pe_req_i[p].addr[5:0] == dma_frontend_pkg::REG_NEXT_ID) begin
                    if (!desc_ready_i || !desc_valid_i) begin
                        err_count_o++;
                        $display("test %0s: PE %0d launch granted without backend handshake",
                                 name_i, p);
                    end
                    if (desc_chk_i[p] && desc_i !== exp_desc_i[p]) begin
                        desc_bad[p] <= 1'b1;
                        desc_got[p] <= desc_i;
                    end
                end
                if (pe_rsp_i[p].valid && !seen_o[p]) begin
                    test_count++;
                    if (pe_rsp_i[p].rdata !== exp_rdata_i[p]) begin
                        err_count_o++;
                        $display("MISMATCH %0s pe%0d rdata expected %h actual %h",
                                 name_i, p, exp_rdata_i[p], pe_rsp_i[p].rdata);
                    end else if (desc_bad[p]) begin
                        err_count_o++;
                        $display("MISMATCH %0s pe%0d descriptor expected %h actual %h",
                                 name_i, p, exp_desc_i[p], desc_got[p]);
                    end else begin
                        $display("ok %0s pe%0d rdata %h", name_i, p, pe_rsp_i[p].rdata);
                    end
                    seen_o[p] <= 1'b1;
                end
            end
        end
        if (timeout_i) begin
            test_count++;
            err_count_o++;
            $display("test %0s: no response from the DUT within the cycle limit", name_i);
        end
        if (finish_i && !summary_done) begin
            summary_done = 1'b1;
            $display("checks: %0d, errors: %0d", test_count, err_count_o);
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: tb/tb_dma_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_frontend;

    localparam int N           = dma_frontend_pkg::NUM_PE;
    localparam int PW          = dma_frontend_pkg::PE_IDX_W;
    localparam int PERIOD_NS   = 4;
    localparam int NUM_ROWS    = 26;
    localparam int CYCLE_LIMIT = 30;
    localparam logic [2:0] OP_WR = 3'd0;
    localparam logic [2:0] OP_RD = 3'd1;
    localparam logic [2:0] OP_LAUNCH = 3'd2;
    localparam logic [2:0] OP_DONE = 3'd3;
    localparam logic [2:0] OP_DUAL = 3'd4;

    typedef struct packed {
        logic [127:0]                    name;
        logic [2:0]                      op;
        logic [PW-1:0]                   pe;
        logic [PW-1:0]                   pe_b;
        logic [5:0]                      off;
        logic [3:0]                      be;
        logic [31:0]                     data;
        logic [3:0]                      stall;
        // expectations for pe, and for pe_b in a dual launch
        logic [31:0]                     exp_rdata;
        logic [31:0]                     exp_rdata_b;
        dma_frontend_pkg::transf_descr_t exp_desc;
        dma_frontend_pkg::transf_descr_t exp_desc_b;
    } row_t;

    logic clk_i;
    logic rst_ni;
    dma_frontend_pkg::tcdm_req_t [N-1:0] pe_req;
    dma_frontend_pkg::tcdm_rsp_t [N-1:0] pe_rsp;
    dma_frontend_pkg::transf_descr_t desc;
    logic desc_valid;
    logic desc_ready;
    logic done;

    logic [N-1:0] chk_en;
    logic [N-1:0] desc_chk;
    logic [N-1:0][31:0] exp_rdata;
    dma_frontend_pkg::transf_descr_t [N-1:0] exp_desc;
    logic [127:0] cur_name;
    logic timeout;
    logic fin;
    logic [N-1:0] seen;
    int err_count;

    row_t rows [NUM_ROWS];
    int row_cnt;
    int seed;

    // reference model state
    dma_frontend_pkg::dma_data_store_t m_store [N];
    logic [2:0]  m_conf [N];
    logic [31:0] m_next_id;
    logic [31:0] m_done_id;
    int          m_ptr;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) i_clk (.clk_o(clk_i));

    dma_frontend_top DUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pe_req_i     (pe_req),
        .pe_rsp_o     (pe_rsp),
        .desc_o       (desc),
        .desc_valid_o (desc_valid),
        .desc_ready_i (desc_ready),
        .done_i       (done)
    );

    dma_frontend_monitor i_monitor (
        .clk_i        (clk_i),
        .pe_req_i     (pe_req),
        .pe_rsp_i     (pe_rsp),
        .desc_i       (desc),
        .desc_valid_i (desc_valid),
        .desc_ready_i (desc_ready),
        .chk_en_i     (chk_en),
        .desc_chk_i   (desc_chk),
        .exp_rdata_i  (exp_rdata),
        .exp_desc_i   (exp_desc),
        .name_i       (cur_name),
        .timeout_i    (timeout),
        .finish_i     (fin),
        .seen_o       (seen),
        .err_count_o  (err_count)
    );

    function automatic logic model_busy();
        return (m_next_id - 32'd1) != m_done_id;
    endfunction

    function automatic logic [31:0] model_read(int pe, logic [5:0] off);
        case (off)
            dma_frontend_pkg::REG_SRC: return m_store[pe].transfer.src_addr;
            dma_frontend_pkg::REG_DST: return m_store[pe].transfer.dst_addr;
            dma_frontend_pkg::REG_NUM: return m_store[pe].transfer.num_bytes;
            dma_frontend_pkg::REG_DONE_ID: return m_done_id;
            dma_frontend_pkg::REG_STATUS: return {15'd0, model_busy(), 13'd0, m_conf[pe]};
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_write(int pe, logic [5:0] off, logic [3:0] be, logic [31:0] data);
        int w;
        w = -1;
        if (off == dma_frontend_pkg::REG_SRC) w = 0;
        if (off == dma_frontend_pkg::REG_DST) w = 1;
        if (off == dma_frontend_pkg::REG_NUM) w = 2;
        if (off == dma_frontend_pkg::REG_STATUS) m_conf[pe] = data[2:0];
        if (w >= 0) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) m_store[pe].bytes[w][i] = data[8*i +: 8];
            end
        end
    endtask

    function automatic dma_frontend_pkg::transf_descr_t model_descr(int pe);
        dma_frontend_pkg::transf_descr_t d;
        d.src_addr  = m_store[pe].transfer.src_addr;
        d.dst_addr  = m_store[pe].transfer.dst_addr;
        d.num_bytes = m_store[pe].transfer.num_bytes;
        d.decouple  = m_conf[pe][0];
        d.deburst   = m_conf[pe][1];
        d.serialize = m_conf[pe][2];
        return d;
    endfunction

    // expected id and descriptor for a launch, advancing the model
    task automatic model_launch(int pe, output logic [31:0] id,
                                output dma_frontend_pkg::transf_descr_t d);
        id        = m_next_id;
        d         = model_descr(pe);
        m_next_id = m_next_id + 32'd1;
        m_ptr     = (pe + 1) % N;
    endtask

    // stimulus plus the model's expectation for it
    task automatic add_row(logic [127:0] name, logic [2:0] op, int pe, int pe_b,
                           logic [5:0] off, logic [3:0] be, logic [31:0] data, int stall);
        row_t row;
        int first;
        row       = '0;
        row.name  = name;
        row.op    = op;
        row.pe    = PW'(pe);
        row.pe_b  = PW'(pe_b);
        row.off   = off;
        row.be    = be;
        row.data  = data;
        row.stall = 4'(stall);
        first     = pe;
        case (op)
            OP_WR: begin
                model_write(pe, off, be, data);
            end
            OP_LAUNCH: begin
                model_launch(pe, row.exp_rdata, row.exp_desc);
            end
            OP_DUAL: begin
                // first of the pair at or after the round-robin pointer goes first
                for (int k = 0; k < N; k++) begin
                    first = (m_ptr + k) % N;
                    if (first == pe || first == pe_b) break;
                end
                if (first == pe) begin
                    model_launch(pe, row.exp_rdata, row.exp_desc);
                    model_launch(pe_b, row.exp_rdata_b, row.exp_desc_b);
                end else begin
                    model_launch(pe_b, row.exp_rdata_b, row.exp_desc_b);
                    model_launch(pe, row.exp_rdata, row.exp_desc);
                end
            end
            OP_DONE: begin
                m_done_id     = m_done_id + 32'd1;
                row.exp_rdata = model_read(pe, off);
            end
            default: begin
                row.exp_rdata = model_read(pe, off);
            end
        endcase
        rows[row_cnt] = row;
        row_cnt++;
    endtask

    task automatic build_table();
        row_cnt = 0;
        add_row("wr_src_full", OP_WR, 0, 0, dma_frontend_pkg::REG_SRC, 4'hf, $random(seed), 0);
        add_row("wr_src_part", OP_WR, 0, 0, dma_frontend_pkg::REG_SRC, 4'h5, $random(seed), 0);
        add_row("rd_src", OP_RD, 0, 0, dma_frontend_pkg::REG_SRC, 4'hf, 0, 0);
        add_row("wr_dst_part", OP_WR, 0, 0, dma_frontend_pkg::REG_DST, 4'hc, $random(seed), 0);
        add_row("rd_dst", OP_RD, 0, 0, dma_frontend_pkg::REG_DST, 4'hf, 0, 0);
        add_row("wr_num_part", OP_WR, 0, 0, dma_frontend_pkg::REG_NUM, 4'h3, $random(seed), 0);
        add_row("rd_num", OP_RD, 0, 0, dma_frontend_pkg::REG_NUM, 4'hf, 0, 0);
        add_row("rd_status_rst", OP_RD, 1, 0, dma_frontend_pkg::REG_STATUS, 4'hf, 0, 0);
        add_row("wr_status", OP_WR, 1, 0, dma_frontend_pkg::REG_STATUS, 4'hf, 32'h2, 0);
        add_row("rd_status_new", OP_RD, 1, 0, dma_frontend_pkg::REG_STATUS, 4'hf, 0, 0);
        add_row("wr_src_pe1", OP_WR, 1, 0, dma_frontend_pkg::REG_SRC, 4'hf, $random(seed), 0);
        add_row("launch_pe0", OP_LAUNCH, 0, 0, dma_frontend_pkg::REG_NEXT_ID, 4'hf, 0, 0);
        add_row("rd_status_busy", OP_RD, 0, 0, dma_frontend_pkg::REG_STATUS, 4'hf, 0, 0);
        add_row("launch_pe1", OP_LAUNCH, 1, 0, dma_frontend_pkg::REG_NEXT_ID, 4'hf, 0, 0);
        add_row("wr_dst_pe2", OP_WR, 2, 0, dma_frontend_pkg::REG_DST, 4'hf, $random(seed), 0);
        add_row("launch_stall", OP_LAUNCH, 2, 0, dma_frontend_pkg::REG_NEXT_ID, 4'hf, 0, 5);
        add_row("dual_launch", OP_DUAL, 1, 3, dma_frontend_pkg::REG_NEXT_ID, 4'hf, 0, 0);
        add_row("rd_unmapped", OP_RD, 2, 0, 6'h30, 4'hf, 0, 0);
        add_row("wr_next_id", OP_WR, 2, 0, dma_frontend_pkg::REG_NEXT_ID, 4'hf, 32'hff, 0);
        add_row("rd_done_0", OP_RD, 3, 0, dma_frontend_pkg::REG_DONE_ID, 4'hf, 0, 0);
        for (int i = 0; i < 5; i++) begin
            add_row("done_pulse", OP_DONE, i % N, 0, dma_frontend_pkg::REG_DONE_ID, 4'hf, 0, 0);
        end
        add_row("rd_status_idle", OP_RD, 0, 0, dma_frontend_pkg::REG_STATUS, 4'hf, 0, 0);
    endtask

    task automatic drive_req(int pe, logic rd, logic [5:0] off, logic [3:0] be,
                             logic [31:0] data);
        pe_req[pe].req   = 1'b1;
        pe_req[pe].rd    = rd;
        pe_req[pe].be    = be;
        pe_req[pe].addr  = {26'd0, off};
        pe_req[pe].wdata = data;
        chk_en[pe]       = 1'b1;
    endtask

    task automatic run_row(int r);
        row_t row;
        int pe;
        int pe_b;
        int cycles;
        int stall_left;
        logic [N-1:0] granted;
        row = rows[r];
        pe = int'(row.pe);
        pe_b = int'(row.pe_b);
        stall_left = int'(row.stall);
        @(posedge clk_i);
        #1;
        cur_name = row.name;
        if (row.op == OP_DONE) begin
            done = 1'b1;
            @(posedge clk_i);
            #1;
            done = 1'b0;
        end
        exp_rdata[pe] = row.exp_rdata;
        case (row.op)
            OP_WR: begin
                drive_req(pe, 1'b0, row.off, row.be, row.data);
            end
            OP_LAUNCH: begin
                exp_desc[pe] = row.exp_desc;
                desc_chk[pe] = 1'b1;
                drive_req(pe, 1'b1, row.off, row.be, 32'd0);
            end
            OP_DUAL: begin
                exp_rdata[pe_b] = row.exp_rdata_b;
                exp_desc[pe]    = row.exp_desc;
                exp_desc[pe_b]  = row.exp_desc_b;
                desc_chk[pe]    = 1'b1;
                desc_chk[pe_b]  = 1'b1;
                drive_req(pe, 1'b1, row.off, row.be, 32'd0);
                drive_req(pe_b, 1'b1, row.off, row.be, 32'd0);
            end
            default: begin
                drive_req(pe, 1'b1, row.off, row.be, 32'd0);
            end
        endcase
        desc_ready = (stall_left == 0);
        cycles = 0;
        while ((seen & chk_en) != chk_en && cycles < CYCLE_LIMIT) begin
            @(negedge clk_i);
            for (int p = 0; p < N; p++) begin
                granted[p] = pe_req[p].req && pe_rsp[p].gnt;
            end
            @(posedge clk_i);
            #1;
            for (int p = 0; p < N; p++) begin
                if (granted[p]) pe_req[p].req = 1'b0;
            end
            if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) desc_ready = 1'b1;
            end
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            timeout = 1'b1;
            @(posedge clk_i);
            #1;
            timeout = 1'b0;
        end
        pe_req     = '0;
        desc_ready = 1'b1;
        chk_en     = '0;
        desc_chk   = '0;
    endtask

    initial begin
        seed       = 32'h538e;
        rst_ni     = 1'b0;
        pe_req     = '0;
        desc_ready = 1'b1;
        done       = 1'b0;
        chk_en     = '0;
        desc_chk   = '0;
        exp_rdata  = '0;
        exp_desc   = '0;
        cur_name   = '0;
        timeout    = 1'b0;
        fin        = 1'b0;
        for (int p = 0; p < N; p++) begin
            m_store[p] = '0;
            m_conf[p]  = dma_frontend_pkg::CONF_RESET;
        end
        m_next_id = 32'd1;
        m_done_id = 32'd0;
        m_ptr     = 0;
        build_table();
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int r = 0; r < row_cnt; r++) begin
            run_row(r);
        end
        fin = 1'b1;
        repeat (2) @(posedge clk_i);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // reset plus 40 cycles per table row
    initial begin
        #((NUM_ROWS * 40 + 10) * PERIOD_NS);
        $display("watchdog expired before the test table finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
